// ==== all.f ====
+incdir+hw
hw/tcb_pkg.sv
hw/tcb_man.sv
hw/tcb_dec.sv
hw/tcb_mem.sv
hw/tcb_mux.sv
hw/tcb_sys.sv
bench/tcb_sys_tb.sv

// ==== Makefile ====
# Verilator flow for the TCB memory cluster

VERILATOR ?= verilator
FLIST     ?= all.f
TB_TOP    ?= tcb_sys_tb
RTL_TOP   ?= tcb_sys
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

# RTL sources only, taken from the file list
RTL_SRCS  ?= $(filter hw/%.sv,$(shell cat $(FLIST)))
SIM_BIN   := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+hw $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
	  --Mdir $(OBJ_DIR) -o V$(TB_TOP)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tcb_sys_tb.sv ====
// TCB memory cluster testbench
`default_nettype none
`include "tcb_defs.svh"

module tcb_sys_tb
  import tcb_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_REF   = `TCB_BANKS * `TCB_MEM_WORDS;
  // rough command total over all tests
  localparam int N_CMD   = 240;
  localparam int WDG_CYC = N_CMD * 40 + 16;

  typedef logic [`TCB_WRD_W-1:0] wrd_t;
  typedef logic [`TCB_OFF_W-1:0] off_t;

  logic                  bus;
  logic                  rst;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  cmd_wen;
  tcb_adr_u              cmd_adr;
  logic [`TCB_BEN_W-1:0] cmd_ben;
  logic [`TCB_DAT_W-1:0] cmd_wdt;
  logic                  rsp_vld;
  logic                  rsp_rdy = 1'b0;
  logic [`TCB_DAT_W-1:0] rsp_rdt;
  logic                  rsp_err;
  logic [`TCB_LEN_W-1:0] rsp_len;

  tcb_sys dut_i (.*);

  ////////////////////////////////////////
  // clock and response ready
  ////////////////////////////////////////

  initial begin
    bus = 1'b0;
    forever #10 bus = ~bus;
  end

  int seed     = 59;
  bit rdy_rnd  = 1'b0;
  bit rdy_hold = 1'b1;
  bit rdy_nxt  = 1'b0;
  int r_rdy;

  // held level, or a coin toss per cycle
  always @(posedge bus) begin
    r_rdy   = $random(seed);
    rdy_nxt = rdy_rnd ? r_rdy[0] : rdy_hold;
  end

  always @(negedge bus) rsp_rdy <= rdy_nxt;

  ////////////////////////////////////////
  // reference memory and scoreboard
  ////////////////////////////////////////

  logic [`TCB_DAT_W-1:0] ref_mem [N_REF];
  // bytes written so far
  logic [`TCB_BEN_W-1:0] ref_kn  [N_REF];
  // expected response per command, in order
  logic [`TCB_DAT_W-1:0] sb_rdt [256];
  logic [`TCB_DAT_W-1:0] sb_msk [256];
  logic                  sb_err [256];
  logic [`TCB_LEN_W-1:0] sb_lo  [256];
  logic [`TCB_LEN_W-1:0] sb_hi  [256];
  logic [7:0]            sb_head;
  logic [7:0]            sb_tail;
  logic [`TCB_LEN_W-1:0] len_lo;
  logic [`TCB_LEN_W-1:0] len_hi;
  logic [`TCB_BNK_W+`TCB_WRD_W-1:0] m_idx;
  logic                  m_mis;
  logic [`TCB_DAT_W-1:0] m_msk;
  logic                  acc_q;
  int                    cmd_cnt;
  int                    rsp_cnt;
  int                    err_cnt;

  // every accepted command updates the model
  always @(posedge bus) begin
    acc_q <= cmd_vld && cmd_rdy;
    if (rst) begin
      sb_tail <= '0;
      cmd_cnt <= 0;
      for (int i = 0; i < N_REF; i++) ref_kn[i] = '0;
    end else if (cmd_vld && cmd_rdy) begin
      m_idx = {cmd_adr.fld.bnk, cmd_adr.fld.wrd};
      m_mis = (cmd_adr.fld.off != '0);
      m_msk = '0;
      // byte merge, misaligned writes dropped
      if (cmd_wen && !m_mis) begin
        for (int b = 0; b < `TCB_BEN_W; b++) begin
          if (cmd_ben[b]) begin
            ref_mem[m_idx][8*b +: 8] = cmd_wdt[8*b +: 8];
            ref_kn[m_idx][b] = 1'b1;
          end
        end
      end
      // compare only known bytes of aligned reads
      if (!cmd_wen && !m_mis) begin
        for (int b = 0; b < `TCB_BEN_W; b++) m_msk[8*b +: 8] = {8{ref_kn[m_idx][b]}};
      end
      sb_rdt[sb_tail] <= ref_mem[m_idx];
      sb_msk[sb_tail] <= m_msk;
      sb_err[sb_tail] <= m_mis;
      sb_lo[sb_tail]  <= len_lo;
      sb_hi[sb_tail]  <= len_hi;
      sb_tail <= sb_tail + 8'd1;
      cmd_cnt <= cmd_cnt + 1;
    end
  end

  always @(posedge bus) begin
    if (rst) begin
      sb_head <= '0;
      rsp_cnt <= 0;
    end else if (rsp_vld && rsp_rdy) begin
      sb_head <= sb_head + 8'd1;
      rsp_cnt <= rsp_cnt + 1;
    end
  end

  // scoreboard head
  logic [`TCB_DAT_W-1:0] hd_rdt;
  logic [`TCB_DAT_W-1:0] hd_msk;
  logic                  hd_err;
  logic [`TCB_LEN_W-1:0] hd_lo;
  logic [`TCB_LEN_W-1:0] hd_hi;
  assign hd_rdt = sb_rdt[sb_head];
  assign hd_msk = sb_msk[sb_head];
  assign hd_err = sb_err[sb_head];
  assign hd_lo  = sb_lo[sb_head];
  assign hd_hi  = sb_hi[sb_head];

  ////////////////////////////////////////
  // response checks
  ////////////////////////////////////////

  a_rst_idle: assert property (@(posedge bus) $fell(rst) |-> cmd_rdy && !rsp_vld)
    else begin
      $display("CHECK FAILED t=%0t cmd_rdy exp=1 got=%b rsp_vld exp=0 got=%b", $time,
               $sampled(cmd_rdy), $sampled(rsp_vld));
      err_cnt++;
    end

  a_rsp_rdt: assert property (@(posedge bus) disable iff (rst)
    rsp_vld && rsp_rdy |-> ((rsp_rdt ^ hd_rdt) & hd_msk) == '0)
    else begin
      $display("CHECK FAILED t=%0t rsp_rdt exp=%h got=%h", $time,
               $sampled(hd_rdt) & $sampled(hd_msk), $sampled(rsp_rdt) & $sampled(hd_msk));
      err_cnt++;
    end

  a_rsp_err: assert property (@(posedge bus) disable iff (rst)
    rsp_vld && rsp_rdy |-> rsp_err == hd_err)
    else begin
      $display("CHECK FAILED t=%0t rsp_err exp=%b got=%b", $time,
               $sampled(hd_err), $sampled(rsp_err));
      err_cnt++;
    end

  // wait length inside the expected window
  a_rsp_len: assert property (@(posedge bus) disable iff (rst)
    rsp_vld && rsp_rdy |-> rsp_len >= hd_lo && rsp_len <= hd_hi)
    else begin
      $display("CHECK FAILED t=%0t rsp_len exp=%0d..%0d got=%0d", $time,
               $sampled(hd_lo), $sampled(hd_hi), $sampled(rsp_len));
      err_cnt++;
    end

  a_rsp_any: assert property (@(posedge bus) disable iff (rst) rsp_vld |-> sb_head != sb_tail)
    else begin
      $display("response at t=%0t without any command outstanding", $time);
      err_cnt++;
    end

  a_rsp_hold: assert property (@(posedge bus) disable iff (rst)
    rsp_vld && !rsp_rdy |=> rsp_vld && $stable(rsp_rdt) && $stable(rsp_err) && $stable(rsp_len))
    else begin
      $display("response payload changed while stalled at t=%0t", $time);
      err_cnt++;
    end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  function automatic logic [`TCB_ADR_W-1:0] make_adr(tcb_bank_t bnk, wrd_t wrd, off_t off);
    tcb_adr_u u;
    u = '0;
    u.fld.bnk = bnk;
    u.fld.wrd = wrd;
    u.fld.off = off;
    return u.raw;
  endfunction

  // one command, gives up after limit cycles
  task automatic send(input logic w, input logic [`TCB_ADR_W-1:0] a,
                      input logic [`TCB_BEN_W-1:0] b, input logic [`TCB_DAT_W-1:0] d,
                      input logic [`TCB_LEN_W-1:0] lo, input logic [`TCB_LEN_W-1:0] hi,
                      input int limit, output bit acc);
    int n;
    cmd_vld = 1'b1;
    cmd_wen = w;
    cmd_adr = a;
    cmd_ben = b;
    cmd_wdt = d;
    len_lo  = lo;
    len_hi  = hi;
    acc = 1'b0;
    n = 0;
    while (!acc && n < limit) begin
      @(posedge bus);
      @(negedge bus);
      acc = acc_q;
      n++;
    end
    cmd_vld = 1'b0;
  endtask

  task automatic wait_idle();
    while (sb_head != sb_tail) @(negedge bus);
    // let write recovery settle
    repeat (2) @(negedge bus);
  endtask

  int err_mark = 0;
  int n_pass = 0;
  int n_fail = 0;

  task automatic test_done(input string name);
    if (err_cnt == err_mark) begin
      n_pass++;
      $display("%-24s ok", name);
    end else begin
      n_fail++;
      $display("%-24s %0d errors", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // watchdog
  initial begin
    repeat (WDG_CYC) @(posedge bus);
    $display("run did not finish within %0d cycles", WDG_CYC);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  initial begin
    bit acc;
    int n_acc;
    int r;
    int rsp_base;
    logic [`TCB_DAT_W-1:0] d;
    rst = 1'b1;
    cmd_vld = 1'b0;
    cmd_wen = 1'b0;
    cmd_adr = '0;
    cmd_ben = '0;
    cmd_wdt = '0;
    len_lo = '0;
    len_hi = '1;
    err_cnt = 0;
    repeat (16) @(negedge bus);
    rst = 1'b0;
    repeat (2) @(negedge bus);
    test_done("reset state");

    // full word per bank, then a partial overwrite
    for (int k = 0; k < `TCB_BANKS; k++) begin
      d = $random(seed);
      send(1'b1, make_adr(tcb_bank_t'(k), wrd_t'(k + 1), 0), 4'hf, d, 0, 255, 1000, acc);
      d = $random(seed);
      send(1'b1, make_adr(tcb_bank_t'(k), wrd_t'(k + 1), 0), 4'b0101, d, 0, 255, 1000, acc);
    end
    for (int k = 0; k < `TCB_BANKS; k++) begin
      send(1'b0, make_adr(tcb_bank_t'(k), wrd_t'(k + 1), 0), 4'h0, '0, 0, 255, 1000, acc);
    end
    wait_idle();
    test_done("write and read back");

    send(1'b1, make_adr(3, 5, 0), 4'hf, 32'h1234_5678, 0, 255, 1000, acc);
    send(1'b1, make_adr(3, 5, 2), 4'hf, 32'hdead_beef, 0, 255, 1000, acc);
    send(1'b0, make_adr(3, 5, 0), 4'h0, '0, 0, 255, 1000, acc);
    send(1'b0, make_adr(3, 5, 1), 4'h0, '0, 0, 255, 1000, acc);
    wait_idle();
    test_done("misaligned access");

    // distinct data behind every word read below
    for (int i = 0; i < 2 * `TCB_QUE_DEPTH; i++) begin
      d = 32'h5a00_0000 + i;
      send(1'b1, make_adr(tcb_bank_t'(i), wrd_t'(i), 0), 4'hf, d, 0, 255, 1000, acc);
    end
    wait_idle();

    // both queues fill, then cmd_rdy drops
    rdy_hold = 1'b0;
    repeat (2) @(negedge bus);
    n_acc = 0;
    acc = 1'b1;
    while (acc && n_acc < 3 * `TCB_QUE_DEPTH) begin
      send(1'b0, make_adr(tcb_bank_t'(n_acc), wrd_t'(n_acc), 0), 4'h0, '0, 0, 255, 10, acc);
      if (acc) n_acc++;
    end
    assert (n_acc == 2 * `TCB_QUE_DEPTH)
      else begin
        $display("CHECK FAILED t=%0t accepted exp=%0d got=%0d", $time,
                 2 * `TCB_QUE_DEPTH, n_acc);
        err_cnt++;
      end
    assert (!cmd_rdy)
      else begin
        $display("CHECK FAILED t=%0t cmd_rdy exp=0 got=%b", $time, cmd_rdy);
        err_cnt++;
      end
    rdy_hold = 1'b1;
    wait_idle();
    test_done("back-pressure");

    send(1'b1, make_adr(0, 9, 0), 4'hf, 32'h0bad_cafe, 0, 255, 1000, acc);
    send(1'b0, make_adr(0, 9, 0), 4'h0, '0, 1, 255, 1000, acc);
    wait_idle();
    send(1'b0, make_adr(1, 2, 0), 4'h0, '0, 0, 0, 1000, acc);
    send(1'b0, make_adr(2, 3, 0), 4'h0, '0, 0, 0, 1000, acc);
    wait_idle();
    test_done("write recovery");

    // random traffic on a few words per bank
    rsp_base = rsp_cnt;
    rdy_rnd = 1'b1;
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      d = $random(seed);
      if (r[15]) @(negedge bus);
      send(r[0], make_adr(r[2:1], wrd_t'(r[5:3]), (r[8:6] == 3'd0) ? r[10:9] : 2'd0),
           r[14:11], d, 0, 255, 1000, acc);
    end
    rdy_rnd = 1'b0;
    wait_idle();
    assert (rsp_cnt - rsp_base == 200)
      else begin
        $display("CHECK FAILED t=%0t rsp_cnt exp=%0d got=%0d", $time, 200,
                 rsp_cnt - rsp_base);
        err_cnt++;
      end
    test_done("random mix");

    $display("tests passed %0d, failed %0d, commands %0d", n_pass, n_fail, cmd_cnt);
    if (n_fail == 0 && err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/tcb_sys.sv ====
// TCB memory cluster top
`default_nettype none
`include "tcb_defs.svh"

module tcb_sys
  import tcb_pkg::*;
(
  input  logic                  bus,
  input  logic                  rst,
  // command port
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  input  logic                  cmd_wen,
  input  tcb_adr_u              cmd_adr,
  input  logic [`TCB_BEN_W-1:0] cmd_ben,
  input  logic [`TCB_DAT_W-1:0] cmd_wdt,
  // response port
  output logic                  rsp_vld,
  input  logic                  rsp_rdy,
  output logic [`TCB_DAT_W-1:0] rsp_rdt,
  output logic                  rsp_err,
  output logic [`TCB_LEN_W-1:0] rsp_len
);

  ////////////////////////////////////////
  // internal bus
  ////////////////////////////////////////

  logic                  vld;
  logic                  rdy;
  logic                  wen;
  tcb_adr_u              adr;
  logic [`TCB_BEN_W-1:0] ben;
  logic [`TCB_DAT_W-1:0] wdt;
  logic [`TCB_DAT_W-1:0] rdt;
  logic                  err;
  tcb_bank_t             sel;
  logic [`TCB_BANKS-1:0] bank_vld;
  logic [`TCB_BANKS-1:0] bank_rdy;
  logic [`TCB_BANKS-1:0] bank_err;
  logic [`TCB_DAT_W-1:0] bank_rdt [`TCB_BANKS];

  // queued manager
  tcb_man man_i (
    .bus, .rst,
    .cmd_vld, .cmd_rdy, .cmd_wen, .cmd_adr, .cmd_ben, .cmd_wdt,
    .rsp_vld, .rsp_rdy, .rsp_rdt, .rsp_err, .rsp_len,
    .vld, .rdy, .wen, .adr, .ben, .wdt, .rdt, .err
  );

  // bank select
  tcb_dec dec_i (.adr, .vld, .rdy, .bank_vld, .bank_rdy, .sel);

  // identical banks, shared request fields
  for (genvar k = 0; k < `TCB_BANKS; k++) begin : gen_bank
    tcb_mem mem_i (
      .bus, .rst, .vld(bank_vld[k]), .rdy(bank_rdy[k]), .wen, .adr, .ben, .wdt,
      .rdt(bank_rdt[k]), .err(bank_err[k])
    );
  end

  // response return
  tcb_mux mux_i (.bus, .rst, .vld, .rdy, .sel, .bank_rdt, .bank_err, .rdt, .err);

endmodule

`default_nettype wire

// ==== hw/tcb_mux.sv ====
// TCB response multiplexer
`default_nettype none
`include "tcb_defs.svh"

module tcb_mux
  import tcb_pkg::*;
(
  input  logic                  bus,
  input  logic                  rst,
  // transfer detection
  input  logic                  vld,
  input  logic                  rdy,
  input  tcb_bank_t             sel,
  // bank responses
  input  logic [`TCB_DAT_W-1:0] bank_rdt [`TCB_BANKS],
  input  logic [`TCB_BANKS-1:0] bank_err,
  // merged response to the manager
  output logic [`TCB_DAT_W-1:0] rdt,
  output logic                  err
);

  ////////////////////////////////////////
  // transfer tracking
  ////////////////////////////////////////

  // response due this cycle
  logic      pnd;
  // bank of the last transfer
  tcb_bank_t sel_q;

  always_ff @(posedge bus) begin
    if (rst) begin
      pnd <= 1'b0;
    end else begin
      pnd <= vld && rdy;
    end
  end

  always_ff @(posedge bus) begin
    if (vld && rdy) sel_q <= sel;
  end

  ////////////////////////////////////////
  // output select
  ////////////////////////////////////////

  // quiet outside response cycles
  assign rdt = pnd ? bank_rdt[sel_q] : '0;
  assign err = pnd && bank_err[sel_q];

  // only the bank owning the pending response may flag an error
  a_err_src: assert property (@(posedge bus) disable iff (rst)
    |bank_err |-> pnd && $onehot(bank_err) && bank_err[sel_q])
    else $error("error from a bank without a pending response");

endmodule

`default_nettype wire

// ==== hw/tcb_mem.sv ====
// TCB memory bank
`default_nettype none
`include "tcb_defs.svh"

module tcb_mem
  import tcb_pkg::*;
(
  input  logic                  bus,
  input  logic                  rst,
  // TCB bus, vld from the decoder
  input  logic                  vld,
  output logic                  rdy,
  input  logic                  wen,
  input  tcb_adr_u              adr,
  input  logic [`TCB_BEN_W-1:0] ben,
  input  logic [`TCB_DAT_W-1:0] wdt,
  // response, one cycle after the transfer
  output logic [`TCB_DAT_W-1:0] rdt,
  output logic                  err
);

  logic [`TCB_DAT_W-1:0] mem [`TCB_MEM_WORDS];
  logic                  trn;
  logic                  mis;
  logic                  rec;

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  assign trn = vld && rdy;
  // any byte offset is misaligned
  assign mis = (adr.fld.off != '0);
  // busy for one cycle after a write
  assign rdy = !rec;

  always_ff @(posedge bus) begin
    if (rst) begin
      rec <= 1'b0;
      err <= 1'b0;
    end else begin
      rec <= trn && wen;
      err <= trn && mis;
    end
  end

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge bus) begin
    // byte merge, misaligned writes dropped
    if (trn && wen && !mis) begin
      for (int b = 0; b < `TCB_BEN_W; b++) begin
        if (ben[b]) mem[adr.fld.wrd][8*b +: 8] <= wdt[8*b +: 8];
      end
    end
    // registered read
    if (trn && !wen) rdt <= mem[adr.fld.wrd];
  end

endmodule

`default_nettype wire

// ==== hw/tcb_dec.sv ====
// TCB address decoder
`default_nettype none
`include "tcb_defs.svh"

module tcb_dec
  import tcb_pkg::*;
(
  // TCB bus from the manager
  input  tcb_adr_u               adr,
  input  logic                   vld,
  output logic                   rdy,
  // per bank handshake
  output logic [`TCB_BANKS-1:0]  bank_vld,
  input  logic [`TCB_BANKS-1:0]  bank_rdy,
  // selected bank, for the response mux
  output tcb_bank_t              sel
);

  ////////////////////////////////////////
  // bank select
  ////////////////////////////////////////

  // bank index straight from the field view
  assign sel = adr.fld.bnk;

  // only the addressed bank sees vld
  always_comb begin
    for (int k = 0; k < `TCB_BANKS; k++) begin
      bank_vld[k] = vld && (sel == tcb_bank_t'(k));
    end
  end

  ////////////////////////////////////////
  // ready return
  ////////////////////////////////////////

  // ready of the addressed bank, valid or not
  // manager only samples it together with vld
  assign rdy = bank_rdy[sel];

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // at most one bank addressed per cycle
  always_comb begin
    assert ($onehot0(bank_vld))
      else $error("more than one bank selected");
  end

endmodule

`default_nettype wire

// ==== hw/tcb_man.sv ====
// TCB bus manager
`default_nettype none
`include "tcb_defs.svh"

module tcb_man
  import tcb_pkg::*;
(
  input  logic                  bus,
  input  logic                  rst,
  // command port
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  input  logic                  cmd_wen,
  input  tcb_adr_u              cmd_adr,
  input  logic [`TCB_BEN_W-1:0] cmd_ben,
  input  logic [`TCB_DAT_W-1:0] cmd_wdt,
  // response port
  output logic                  rsp_vld,
  input  logic                  rsp_rdy,
  output logic [`TCB_DAT_W-1:0] rsp_rdt,
  output logic                  rsp_err,
  output logic [`TCB_LEN_W-1:0] rsp_len,
  // TCB bus
  output logic                  vld,
  input  logic                  rdy,
  output logic                  wen,
  output tcb_adr_u              adr,
  output logic [`TCB_BEN_W-1:0] ben,
  output logic [`TCB_DAT_W-1:0] wdt,
  input  logic [`TCB_DAT_W-1:0] rdt,
  input  logic                  err
);

  localparam int QD = `TCB_QUE_DEPTH;
  localparam int QA = $clog2(QD);

  ////////////////////////////////////////
  // request queue
  ////////////////////////////////////////

  // pointers carry one extra wrap bit
  logic [QA:0]           req_wp;
  logic [QA:0]           req_rp;
  logic                  req_full;
  logic                  req_empty;
  logic                  req_push;
  logic                  req_wen_m [QD];
  tcb_adr_u              req_adr_m [QD];
  logic [`TCB_BEN_W-1:0] req_ben_m [QD];
  logic [`TCB_DAT_W-1:0] req_wdt_m [QD];

  assign req_empty = (req_wp == req_rp);
  assign req_full  = (req_wp[QA] != req_rp[QA]) && (req_wp[QA-1:0] == req_rp[QA-1:0]);
  assign cmd_rdy   = !req_full;
  assign req_push  = cmd_vld && cmd_rdy;

  // payload storage
  always_ff @(posedge bus) begin
    if (req_push) begin
      req_wen_m[req_wp[QA-1:0]] <= cmd_wen;
      req_adr_m[req_wp[QA-1:0]] <= cmd_adr;
      req_ben_m[req_wp[QA-1:0]] <= cmd_ben;
      req_wdt_m[req_wp[QA-1:0]] <= cmd_wdt;
    end
  end

  ////////////////////////////////////////
  // transfer issue
  ////////////////////////////////////////

  logic                  trn;
  logic                  trn_dly;
  logic                  issue_ok;
  logic [QA:0]           rsp_wp;
  logic [QA:0]           rsp_rp;
  logic [QA:0]           rsp_used;
  logic [`TCB_LEN_W-1:0] len_cnt;
  logic [`TCB_LEN_W-1:0] len_dly;

  // room for the response in flight plus this one
  assign rsp_used = rsp_wp - rsp_rp;
  assign issue_ok = (int'(rsp_used) + int'(trn_dly)) < QD;

  // queue head drives the bus directly
  assign vld = !req_empty && issue_ok;
  assign wen = req_wen_m[req_rp[QA-1:0]];
  assign adr = req_adr_m[req_rp[QA-1:0]];
  assign ben = req_ben_m[req_rp[QA-1:0]];
  assign wdt = req_wdt_m[req_rp[QA-1:0]];
  assign trn = vld && rdy;

  always_ff @(posedge bus) begin
    if (rst) begin
      req_wp  <= '0;
      req_rp  <= '0;
      trn_dly <= 1'b0;
      len_cnt <= '0;
    end else begin
      if (req_push) req_wp <= req_wp + 1'b1;
      if (trn)      req_rp <= req_rp + 1'b1;
      // response arrives one cycle after the transfer
      trn_dly <= trn;
      // wait cycles, saturating
      if (trn) begin
        len_cnt <= '0;
      end else if (vld && (len_cnt != '1)) begin
        len_cnt <= len_cnt + 1'b1;
      end
    end
  end

  // length travels alongside the transfer
  always_ff @(posedge bus) begin
    if (trn) len_dly <= len_cnt;
  end

  ////////////////////////////////////////
  // response queue
  ////////////////////////////////////////

  logic                  rsp_pop;
  logic                  rsp_full;
  logic [`TCB_DAT_W-1:0] rsp_rdt_m [QD];
  logic                  rsp_err_m [QD];
  logic [`TCB_LEN_W-1:0] rsp_len_m [QD];

  assign rsp_vld  = (rsp_wp != rsp_rp);
  assign rsp_full = (rsp_wp[QA] != rsp_rp[QA]) && (rsp_wp[QA-1:0] == rsp_rp[QA-1:0]);
  assign rsp_pop  = rsp_vld && rsp_rdy;
  assign rsp_rdt  = rsp_rdt_m[rsp_rp[QA-1:0]];
  assign rsp_err  = rsp_err_m[rsp_rp[QA-1:0]];
  assign rsp_len  = rsp_len_m[rsp_rp[QA-1:0]];

  always_ff @(posedge bus) begin
    if (trn_dly) begin
      rsp_rdt_m[rsp_wp[QA-1:0]] <= rdt;
      rsp_err_m[rsp_wp[QA-1:0]] <= err;
      rsp_len_m[rsp_wp[QA-1:0]] <= len_dly;
    end
  end

  always_ff @(posedge bus) begin
    if (rst) begin
      rsp_wp <= '0;
      rsp_rp <= '0;
    end else begin
      if (trn_dly) rsp_wp <= rsp_wp + 1'b1;
      if (rsp_pop) rsp_rp <= rsp_rp + 1'b1;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // stalled request holds until the transfer
  a_req_hold: assert property (@(posedge bus) disable iff (rst)
    vld && !rdy |=> vld && $stable(wen) && $stable(adr) && $stable(ben) && $stable(wdt))
    else $error("request changed while stalled");

  // issue gating keeps a slot for every response in flight
  a_rsp_room: assert property (@(posedge bus) disable iff (rst) trn_dly |-> !rsp_full)
    else $error("response queue overflow");

endmodule

`default_nettype wire

// ==== hw/tcb_pkg.sv ====
// TCB shared types
`default_nettype none
`include "tcb_defs.svh"

package tcb_pkg;

  ////////////////////////////////////////
  // bank index
  ////////////////////////////////////////

  // selects one of the banks
  typedef logic [`TCB_BNK_W-1:0] tcb_bank_t;

  ////////////////////////////////////////
  // address decoding
  ////////////////////////////////////////

  // field view, msb first
  typedef struct packed {
    // high bits above the cluster, ignored
    logic [`TCB_ADR_W-`TCB_BNK_W-`TCB_WRD_W-`TCB_OFF_W-1:0] unu;
    // bank index
    tcb_bank_t                                             bnk;
    // word index inside the bank
    logic [`TCB_WRD_W-1:0]                                 wrd;
    // byte offset, non-zero means misaligned
    logic [`TCB_OFF_W-1:0]                                 off;
  } tcb_adr_f_t;

  // one address word, two views
  typedef union packed {
    // flat word as issued by the manager
    logic [`TCB_ADR_W-1:0] raw;
    // decoded fields
    tcb_adr_f_t            fld;
  } tcb_adr_u;

endpackage

`default_nettype wire

// ==== hw/tcb_defs.svh ====
// TCB cluster widths and sizes
`ifndef TCB_DEFS_SVH
`define TCB_DEFS_SVH

////////////////////////////////////////
// bus widths
////////////////////////////////////////

// address width
`define TCB_ADR_W 32
// data width
`define TCB_DAT_W 32
// byte enable width, one bit per byte
`define TCB_BEN_W (`TCB_DAT_W/8)
// byte offset bits inside a word
`define TCB_OFF_W $clog2(`TCB_BEN_W)

////////////////////////////////////////
// memory cluster
////////////////////////////////////////

// bank count, power of two
`define TCB_BANKS 4
`define TCB_BNK_W $clog2(`TCB_BANKS)
// words per bank
`define TCB_MEM_WORDS 64
`define TCB_WRD_W $clog2(`TCB_MEM_WORDS)

// manager queues, power of two, at least 2
`define TCB_QUE_DEPTH 4
// wait length counter width
`define TCB_LEN_W 8

`endif
